// ==== hw/calc_pkg.sv ====
//##############################
// Calculator shared definitions
// Stage count, register ids, opcodes
//##############################

package calc_pkg;

  // Fixed-latency results retire from the last completion stage
  localparam int comp_stages_c = 3;

  localparam int reg_addr_width_c = 5;

  typedef logic [reg_addr_width_c-1:0] calc_reg_addr_t;

  typedef enum logic [3:0]
  {
    op_add  = 4'd0
    , op_sub  = 4'd1
    , op_and  = 4'd2
    , op_or   = 4'd3
    , op_xor  = 4'd4
    , op_slt  = 4'd5
    , op_sll  = 4'd6
    , op_srl  = 4'd7
    , op_mul  = 4'd8
    , op_divu = 4'd9
    , op_remu = 4'd10
  } calc_op_e;

  // Iterative divider control
  typedef enum logic [1:0]
  {
    e_div_idle   = 2'd0
    , e_div_busy = 2'd1
    , e_div_done = 2'd2
  } calc_div_state_e;

endpackage

// ==== hw/calc_issue.sv ====
//##############################
// Calculator issue stage
// Decode, operand bypass and the reservation register
//##############################

`timescale 1ns/100ps

module calc_issue
  #(parameter data_width_p = 32)
  (input                                                         clk_i
   , input                                                       rst_n_i

   , input                                                       dispatch_v_i
   , input calc_pkg::calc_op_e                                   dispatch_op_i
   , input calc_pkg::calc_reg_addr_t                             dispatch_rd_i
   , input calc_pkg::calc_reg_addr_t                             dispatch_rs1_addr_i
   , input calc_pkg::calc_reg_addr_t                             dispatch_rs2_addr_i
   , input [data_width_p-1:0]                                    dispatch_rs1_i
   , input [data_width_p-1:0]                                    dispatch_rs2_i

   , input [calc_pkg::comp_stages_c-1:0]                         stage_w_v_i
   , input calc_pkg::calc_reg_addr_t [calc_pkg::comp_stages_c-1:0] stage_rd_i
   , input [calc_pkg::comp_stages_c-1:0][data_width_p-1:0]       forward_data_i

   , output logic                                                entry_w_v_o
   , output calc_pkg::calc_reg_addr_t                            entry_rd_o

   , output logic                                                int_v_o
   , output logic                                                mul_v_o
   , output logic                                                div_v_o
   , output calc_pkg::calc_op_e                                  res_op_o
   , output calc_pkg::calc_reg_addr_t                            res_rd_o
   , output logic [data_width_p-1:0]                             res_rs1_o
   , output logic [data_width_p-1:0]                             res_rs2_o
   );

  logic is_int, is_mul, is_div, wr_ok;
  logic [data_width_p-1:0] rs1_byp, rs2_byp;

  // Youngest matching stage wins, so scan from the oldest one down
  function automatic logic [data_width_p-1:0] bypass
    (input calc_pkg::calc_reg_addr_t addr
     , input logic [data_width_p-1:0] value
     );
    logic [data_width_p-1:0] sel;
    sel = value;
    for (int i = calc_pkg::comp_stages_c-1; i >= 0; i--)
      if (stage_w_v_i[i] && (stage_rd_i[i] == addr))
        sel = forward_data_i[i];
    return sel;
  endfunction

  always_comb
  begin
    is_int = 1'b0;
    is_mul = 1'b0;
    is_div = 1'b0;
    case (dispatch_op_i)
      calc_pkg::op_mul:                    is_mul = 1'b1;
      calc_pkg::op_divu, calc_pkg::op_remu: is_div = 1'b1;
      default:                             is_int = 1'b1;
    endcase
    rs1_byp = bypass(dispatch_rs1_addr_i, dispatch_rs1_i);
    rs2_byp = bypass(dispatch_rs2_addr_i, dispatch_rs2_i);
  end

  // Register 0 is never written
  assign wr_ok = dispatch_v_i & (dispatch_rd_i != '0);

  // Only fixed-latency ops occupy the completion pipe
  assign entry_w_v_o = wr_ok & (is_int | is_mul);
  assign entry_rd_o  = dispatch_rd_i;

  always_ff @(posedge clk_i or negedge rst_n_i)
    if (!rst_n_i)
    begin
      int_v_o <= 1'b0;
      mul_v_o <= 1'b0;
      div_v_o <= 1'b0;
    end
    else
    begin
      int_v_o <= wr_ok & is_int;
      mul_v_o <= wr_ok & is_mul;
      div_v_o <= wr_ok & is_div;
    end

  always_ff @(posedge clk_i)
  begin
    res_op_o  <= dispatch_op_i;
    res_rd_o  <= dispatch_rd_i;
    res_rs1_o <= rs1_byp;
    res_rs2_o <= rs2_byp;
  end

endmodule

// ==== hw/calc_pipe_int.sv ====
//##############################
// Integer ALU pipe
// Single cycle result from the reservation
//##############################

`timescale 1ns/100ps

module calc_pipe_int
  #(parameter data_width_p = 32)
  (input                              v_i
   , input calc_pkg::calc_op_e        op_i
   , input [data_width_p-1:0]         rs1_i
   , input [data_width_p-1:0]         rs2_i

   , output logic                     v_o
   , output logic [data_width_p-1:0]  data_o
   );

  localparam shamt_width_lp = $clog2(data_width_p);

  logic [shamt_width_lp-1:0] shamt;
  logic                      lt_signed;

  assign shamt     = rs2_i[shamt_width_lp-1:0];
  assign lt_signed = $signed(rs1_i) < $signed(rs2_i);

  always_comb
  begin
    case (op_i)
      calc_pkg::op_add:
        data_o = rs1_i + rs2_i;
      calc_pkg::op_sub:
        data_o = rs1_i - rs2_i;
      calc_pkg::op_and:
        data_o = rs1_i & rs2_i;
      calc_pkg::op_or:
        data_o = rs1_i | rs2_i;
      calc_pkg::op_xor:
        data_o = rs1_i ^ rs2_i;
      calc_pkg::op_slt:
        data_o = {{(data_width_p-1){1'b0}}, lt_signed};
      calc_pkg::op_sll:
        data_o = rs1_i << shamt;
      calc_pkg::op_srl:
        data_o = rs1_i >> shamt;
      default:
        data_o = '0;
    endcase
  end

  // Result lands in completion stage 1 the same cycle
  assign v_o = v_i;

endmodule

// ==== hw/calc_pipe_mul.sv ====
//##############################
// Multiply pipe
// Low half of the product, one register
//##############################

`timescale 1ns/100ps

module calc_pipe_mul
  #(parameter data_width_p = 32)
  (input                              clk_i
   , input                            rst_n_i

   , input                            v_i
   , input [data_width_p-1:0]         rs1_i
   , input [data_width_p-1:0]         rs2_i

   , output logic                     v_o
   , output logic [data_width_p-1:0]  data_o
   );

  logic [data_width_p-1:0] prod;

  // Truncated to the datapath width
  assign prod = rs1_i * rs2_i;

  always_ff @(posedge clk_i or negedge rst_n_i)
    if (!rst_n_i)
      v_o <= 1'b0;
    else
      v_o <= v_i;

  always_ff @(posedge clk_i)
    if (v_i)
      data_o <= prod;

endmodule

// ==== hw/calc_pipe_div.sv ====
//##############################
// Iterative unsigned divider
// One quotient bit per cycle, held until taken
//##############################

`timescale 1ns/100ps

module calc_pipe_div
  #(parameter data_width_p = 32)
  (input                                clk_i
   , input                              rst_n_i

   , input                              v_i
   , input calc_pkg::calc_op_e          op_i
   , input calc_pkg::calc_reg_addr_t    rd_i
   , input [data_width_p-1:0]           rs1_i
   , input [data_width_p-1:0]           rs2_i

   , output logic                       busy_o
   , output logic                       wb_v_o
   , input                              wb_yumi_i
   , output calc_pkg::calc_reg_addr_t   wb_rd_o
   , output logic [data_width_p-1:0]    wb_data_o
   );

  localparam cnt_width_lp = $clog2(data_width_p);

  calc_pkg::calc_div_state_e state_r, state_n;
  logic [cnt_width_lp-1:0]   cnt_r;
  logic [data_width_p-1:0]   quo_r, rem_r, divisor_r;
  calc_pkg::calc_reg_addr_t  rd_r;
  logic                      rem_sel_r;
  logic [data_width_p:0]     rem_shift, rem_diff;
  logic                      start, last_iter;

  assign start     = (state_r == calc_pkg::e_div_idle) & v_i;
  assign last_iter = cnt_r == cnt_width_lp'(data_width_p-1);

  // Bit data_width_p of the trial subtract is set when the divisor did not fit
  assign rem_shift = {rem_r, quo_r[data_width_p-1]};
  assign rem_diff  = rem_shift - {1'b0, divisor_r};

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      calc_pkg::e_div_idle: if (v_i) state_n = calc_pkg::e_div_busy;
      calc_pkg::e_div_busy: if (last_iter) state_n = calc_pkg::e_div_done;
      calc_pkg::e_div_done: if (wb_yumi_i) state_n = calc_pkg::e_div_idle;
      default:              state_n = calc_pkg::e_div_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
    if (!rst_n_i)
    begin
      state_r <= calc_pkg::e_div_idle;
      cnt_r   <= '0;
    end
    else
    begin
      state_r <= state_n;
      if (start)
        cnt_r <= '0;
      else if (state_r == calc_pkg::e_div_busy)
        cnt_r <= cnt_r + 1'b1;
    end

  // A zero divisor always subtracts, giving all ones and the dividend back
  always_ff @(posedge clk_i)
    if (start)
    begin
      quo_r     <= rs1_i;
      rem_r     <= '0;
      divisor_r <= rs2_i;
      rd_r      <= rd_i;
      rem_sel_r <= (op_i == calc_pkg::op_remu);
    end
    else if (state_r == calc_pkg::e_div_busy)
    begin
      quo_r <= {quo_r[data_width_p-2:0], ~rem_diff[data_width_p]};
      rem_r <= rem_diff[data_width_p] ? rem_shift[data_width_p-1:0]
                                      : rem_diff[data_width_p-1:0];
    end

  // Busy already in the cycle the divide is seen
  assign busy_o    = v_i | (state_r != calc_pkg::e_div_idle);
  assign wb_v_o    = (state_r == calc_pkg::e_div_done);
  assign wb_rd_o   = rd_r;
  assign wb_data_o = rem_sel_r ? rem_r : quo_r;

endmodule

// ==== hw/calc_completion.sv ====
//##############################
// Completion pipe
// Result staging, forward data, writeback arbitration
//##############################

`timescale 1ns/100ps

module calc_completion
  #(parameter data_width_p = 32)
  (input                                                          clk_i
   , input                                                        rst_n_i

   , input                                                        entry_w_v_i
   , input calc_pkg::calc_reg_addr_t                              entry_rd_i

   , input                                                        int_v_i
   , input [data_width_p-1:0]                                     int_data_i
   , input                                                        mul_v_i
   , input [data_width_p-1:0]                                     mul_data_i

   , input                                                        div_wb_v_i
   , input calc_pkg::calc_reg_addr_t                              div_wb_rd_i
   , input [data_width_p-1:0]                                     div_wb_data_i
   , output logic                                                 div_wb_yumi_o

   , output logic [calc_pkg::comp_stages_c-1:0]                   stage_w_v_o
   , output calc_pkg::calc_reg_addr_t [calc_pkg::comp_stages_c-1:0] stage_rd_o
   , output logic [calc_pkg::comp_stages_c-1:0][data_width_p-1:0] forward_data_o

   , output logic                                                 wb_v_o
   , output calc_pkg::calc_reg_addr_t                             wb_rd_o
   , output logic [data_width_p-1:0]                              wb_data_o
   );

  localparam stages_lp    = calc_pkg::comp_stages_c;
  localparam last_lp      = stages_lp - 1;
  localparam int_stage_lp = 1;
  localparam mul_stage_lp = 2;

  logic [stages_lp-1:0]                         w_v_r, w_v_n;
  calc_pkg::calc_reg_addr_t [stages_lp-1:0]     rd_r, rd_n;
  logic [stages_lp-1:0][data_width_p-1:0]       data_r, data_n;

  // Entries shift down each cycle and results are ORed in where their pipe finishes
  always_comb
  begin
    w_v_n[0]  = entry_w_v_i;
    rd_n[0]   = entry_rd_i;
    data_n[0] = '0;
    for (int i = 1; i < stages_lp; i++)
    begin
      w_v_n[i]  = w_v_r[i-1];
      rd_n[i]   = rd_r[i-1];
      data_n[i] = data_r[i-1];
    end
    data_n[int_stage_lp] |= int_v_i ? int_data_i : '0;
    data_n[mul_stage_lp] |= mul_v_i ? mul_data_i : '0;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
    if (!rst_n_i)
      w_v_r <= '0;
    else
      w_v_r <= w_v_n;

  always_ff @(posedge clk_i)
  begin
    rd_r   <= rd_n;
    data_r <= data_n;
  end

  // A stage forwards the value it will hold after the next edge
  for (genvar i = 0; i < last_lp; i++)
  begin : fwd
    assign forward_data_o[i] = data_n[i+1];
  end
  assign forward_data_o[last_lp] = data_r[last_lp];

  assign stage_w_v_o = w_v_r;
  assign stage_rd_o  = rd_r;

  // The divider only takes slots that fixed-latency writes leave idle
  assign div_wb_yumi_o = div_wb_v_i & ~w_v_r[last_lp];

  assign wb_v_o    = w_v_r[last_lp] | div_wb_yumi_o;
  assign wb_rd_o   = div_wb_yumi_o ? div_wb_rd_i : rd_r[last_lp];
  assign wb_data_o = div_wb_yumi_o ? div_wb_data_i : data_r[last_lp];

endmodule

// ==== hw/calc_top.sv ====
//##############################
// Integer calculator top
// Issue, execution pipes, completion
//##############################

`timescale 1ns/100ps

module calc_top
  #(parameter data_width_p = 32)
  (input                                clk_i
   , input                              rst_n_i

   , input                              dispatch_v_i
   , input calc_pkg::calc_op_e          dispatch_op_i
   , input calc_pkg::calc_reg_addr_t    dispatch_rd_i
   , input calc_pkg::calc_reg_addr_t    dispatch_rs1_addr_i
   , input calc_pkg::calc_reg_addr_t    dispatch_rs2_addr_i
   , input [data_width_p-1:0]           dispatch_rs1_i
   , input [data_width_p-1:0]           dispatch_rs2_i

   , output logic                       div_busy_o
   , output logic                       wb_v_o
   , output calc_pkg::calc_reg_addr_t   wb_rd_o
   , output logic [data_width_p-1:0]    wb_data_o
   );

  logic                                                 entry_w_v;
  calc_pkg::calc_reg_addr_t                             entry_rd;
  logic [calc_pkg::comp_stages_c-1:0]                   stage_w_v;
  calc_pkg::calc_reg_addr_t [calc_pkg::comp_stages_c-1:0] stage_rd;
  logic [calc_pkg::comp_stages_c-1:0][data_width_p-1:0] forward_data;

  logic                      int_v, mul_v, div_v;
  calc_pkg::calc_op_e        res_op;
  calc_pkg::calc_reg_addr_t  res_rd;
  logic [data_width_p-1:0]   res_rs1, res_rs2;

  logic                      int_res_v, mul_res_v;
  logic [data_width_p-1:0]   int_res, mul_res;

  logic                      div_wb_v, div_wb_yumi;
  calc_pkg::calc_reg_addr_t  div_wb_rd;
  logic [data_width_p-1:0]   div_wb_data;

  calc_issue #(.data_width_p(data_width_p)) issue
    (.clk_i(clk_i), .rst_n_i(rst_n_i)
     , .dispatch_v_i(dispatch_v_i), .dispatch_op_i(dispatch_op_i)
     , .dispatch_rd_i(dispatch_rd_i)
     , .dispatch_rs1_addr_i(dispatch_rs1_addr_i), .dispatch_rs2_addr_i(dispatch_rs2_addr_i)
     , .dispatch_rs1_i(dispatch_rs1_i), .dispatch_rs2_i(dispatch_rs2_i)
     , .stage_w_v_i(stage_w_v), .stage_rd_i(stage_rd), .forward_data_i(forward_data)
     , .entry_w_v_o(entry_w_v), .entry_rd_o(entry_rd)
     , .int_v_o(int_v), .mul_v_o(mul_v), .div_v_o(div_v)
     , .res_op_o(res_op), .res_rd_o(res_rd), .res_rs1_o(res_rs1), .res_rs2_o(res_rs2)
     );

  calc_pipe_int #(.data_width_p(data_width_p)) pipe_int
    (.v_i(int_v), .op_i(res_op), .rs1_i(res_rs1), .rs2_i(res_rs2)
     , .v_o(int_res_v), .data_o(int_res)
     );

  calc_pipe_mul #(.data_width_p(data_width_p)) pipe_mul
    (.clk_i(clk_i), .rst_n_i(rst_n_i)
     , .v_i(mul_v), .rs1_i(res_rs1), .rs2_i(res_rs2)
     , .v_o(mul_res_v), .data_o(mul_res)
     );

  calc_pipe_div #(.data_width_p(data_width_p)) pipe_div
    (.clk_i(clk_i), .rst_n_i(rst_n_i)
     , .v_i(div_v), .op_i(res_op), .rd_i(res_rd), .rs1_i(res_rs1), .rs2_i(res_rs2)
     , .busy_o(div_busy_o), .wb_v_o(div_wb_v), .wb_yumi_i(div_wb_yumi)
     , .wb_rd_o(div_wb_rd), .wb_data_o(div_wb_data)
     );

  calc_completion #(.data_width_p(data_width_p)) completion
    (.clk_i(clk_i), .rst_n_i(rst_n_i)
     , .entry_w_v_i(entry_w_v), .entry_rd_i(entry_rd)
     , .int_v_i(int_res_v), .int_data_i(int_res)
     , .mul_v_i(mul_res_v), .mul_data_i(mul_res)
     , .div_wb_v_i(div_wb_v), .div_wb_rd_i(div_wb_rd), .div_wb_data_i(div_wb_data)
     , .div_wb_yumi_o(div_wb_yumi)
     , .stage_w_v_o(stage_w_v), .stage_rd_o(stage_rd), .forward_data_o(forward_data)
     , .wb_v_o(wb_v_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
     );

endmodule

// ==== test/calc_model.svh ====
//##############################
// Calculator reference model
// Golden results, expected writebacks
//##############################

// Register file in program order
logic [width_lp-1:0]      gold_rf [0:31];

// Fixed-latency writebacks indexed by cycle modulo 4
logic                     exp_v    [0:3];
calc_pkg::calc_reg_addr_t exp_rd   [0:3];
logic [width_lp-1:0]      exp_data [0:3];

// At most one divide is in flight
logic                     div_pend;
calc_pkg::calc_reg_addr_t div_rd;
logic [width_lp-1:0]      div_data;
int                       div_cyc;

function automatic logic [width_lp-1:0] golden_result
  (input calc_pkg::calc_op_e op
   , input logic [width_lp-1:0] a
   , input logic [width_lp-1:0] b
   );
  logic [width_lp-1:0] res;
  res = '0;
  case (op)
    calc_pkg::op_add:  res = a + b;
    calc_pkg::op_sub:  res = a - b;
    calc_pkg::op_and:  res = a & b;
    calc_pkg::op_or:   res = a | b;
    calc_pkg::op_xor:  res = a ^ b;
    calc_pkg::op_slt:  res[0] = $signed(a) < $signed(b);
    calc_pkg::op_sll:  res = a << (b % width_lp);
    calc_pkg::op_srl:  res = a >> (b % width_lp);
    calc_pkg::op_mul:  res = a * b;
    calc_pkg::op_divu: res = (b == '0) ? '1 : a / b;
    calc_pkg::op_remu: res = (b == '0) ? a : a % b;
    default:           res = '0;
  endcase
  return res;
endfunction

function automatic logic fixed_pending();
  return exp_v[0] | exp_v[1] | exp_v[2] | exp_v[3];
endfunction

// Result due 3 cycles later or whenever the divider gets the port
task automatic track_dispatch
  (input calc_pkg::calc_op_e op
   , input calc_pkg::calc_reg_addr_t rd
   , input calc_pkg::calc_reg_addr_t rs1
   , input calc_pkg::calc_reg_addr_t rs2
   , input int cyc_now
   );
  logic [width_lp-1:0] res;
  int                  slot;
  res  = golden_result(op, gold_rf[rs1], gold_rf[rs2]);
  slot = (cyc_now + 3) % 4;
  if (rd != '0)
  begin
    gold_rf[rd] = res;
    if (op == calc_pkg::op_divu || op == calc_pkg::op_remu)
    begin
      div_pend = 1'b1;
      div_rd   = rd;
      div_data = res;
      div_cyc  = cyc_now;
    end
    else
    begin
      exp_v[slot]    = 1'b1;
      exp_rd[slot]   = rd;
      exp_data[slot] = res;
    end
  end
endtask

// ==== test/calc_tb.sv ====
//##############################
// Calculator testbench
// Random dependent traffic against a golden model
//##############################

`timescale 1ns/100ps

module calc_tb;

  localparam int width_lp        = 32;
  localparam int num_instr_lp    = 2000;
  localparam int clk_period_lp   = 100;
  localparam int reset_cycles_lp = 16;

  logic                     clk;
  logic                     rst_n;
  logic                     dispatch_v;
  calc_pkg::calc_op_e       dispatch_op;
  calc_pkg::calc_reg_addr_t dispatch_rd, dispatch_rs1_addr, dispatch_rs2_addr;
  logic [width_lp-1:0]      dispatch_rs1, dispatch_rs2;
  logic                     div_busy, wb_v;
  calc_pkg::calc_reg_addr_t wb_rd;
  logic [width_lp-1:0]      wb_data;

  integer                   seed;
  int                       cyc;
  int                       sent;
  logic                     prev_mul_v;
  calc_pkg::calc_reg_addr_t prev_mul_rd;
  // Written only from the writeback port, so in-flight values are stale
  logic [width_lp-1:0]      rf [0:31];

  `include "calc_model.svh"

  calc_top #(.data_width_p(width_lp)) DUT
    (.clk_i(clk), .rst_n_i(rst_n)
     , .dispatch_v_i(dispatch_v), .dispatch_op_i(dispatch_op), .dispatch_rd_i(dispatch_rd)
     , .dispatch_rs1_addr_i(dispatch_rs1_addr), .dispatch_rs2_addr_i(dispatch_rs2_addr)
     , .dispatch_rs1_i(dispatch_rs1), .dispatch_rs2_i(dispatch_rs2)
     , .div_busy_o(div_busy), .wb_v_o(wb_v), .wb_rd_o(wb_rd), .wb_data_o(wb_data)
     );

  always #(clk_period_lp/2) clk = ~clk;

  task automatic stop_with_failure();
    $display("Done: errors found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (expected == actual)
    else
    begin
      $display("ERR %s expected %0h actual %0h", name, expected, actual);
      stop_with_failure();
    end
  endtask

  // Outputs are sampled on the falling edge, before new stimulus
  task automatic check_cycle();
    int slot;
    @(negedge clk);
    cyc++;
    slot = cyc % 4;
    check_value("divider busy", div_pend, div_busy);
    if (exp_v[slot])
    begin
      check_value("fixed writeback valid", 1, wb_v);
      check_value("fixed writeback rd", exp_rd[slot], wb_rd);
      check_value("fixed writeback data", exp_data[slot], wb_data);
      rf[wb_rd] = wb_data;
      exp_v[slot] = 1'b0;
    end
    else if (wb_v)
    begin
      assert (div_pend)
      else
      begin
        $display("Writeback to r%0d with no result pending", wb_rd);
        stop_with_failure();
      end
      assert (cyc - div_cyc >= width_lp)
      else
      begin
        $display("Divide result came back after only %0d cycles", cyc - div_cyc);
        stop_with_failure();
      end
      check_value("divide writeback rd", div_rd, wb_rd);
      check_value("divide writeback data", div_data, wb_data);
      rf[wb_rd] = wb_data;
      div_pend = 1'b0;
    end
  endtask

  // Dispatch one legal instruction or leave the cycle idle
  task automatic send_random();
    calc_pkg::calc_op_e       op;
    calc_pkg::calc_reg_addr_t rd, rs1, rs2;
    logic                     is_div;
    logic                     legal;
    op     = calc_pkg::calc_op_e'(4'($unsigned($random(seed)) % 11));
    rd     = calc_pkg::calc_reg_addr_t'($unsigned($random(seed)) % 8);
    rs1    = calc_pkg::calc_reg_addr_t'($unsigned($random(seed)) % 8);
    rs2    = calc_pkg::calc_reg_addr_t'($unsigned($random(seed)) % 8);
    is_div = (op == calc_pkg::op_divu) || (op == calc_pkg::op_remu);
    // r0 always reads zero
    if (is_div && (($random(seed) & 3) == 0))
      rs2 = '0;
    legal = ($random(seed) & 3) != 0;
    if (prev_mul_v && (rs1 == prev_mul_rd || rs2 == prev_mul_rd))
      legal = 1'b0;
    if (is_div && div_pend)
      legal = 1'b0;
    if (div_pend && (rs1 == div_rd || rs2 == div_rd || rd == div_rd))
      legal = 1'b0;
    dispatch_v  = legal;
    prev_mul_v  = legal && (op == calc_pkg::op_mul) && (rd != '0);
    prev_mul_rd = rd;
    if (legal)
    begin
      dispatch_op       = op;
      dispatch_rd       = rd;
      dispatch_rs1_addr = rs1;
      dispatch_rs2_addr = rs2;
      dispatch_rs1      = rf[rs1];
      dispatch_rs2      = rf[rs2];
      track_dispatch(op, rd, rs1, rs2, cyc);
      sent++;
    end
  endtask

  initial
  begin
    seed              = 51;
    clk               = 1'b0;
    rst_n             = 1'b0;
    dispatch_v        = 1'b0;
    dispatch_op       = calc_pkg::op_add;
    dispatch_rd       = '0;
    dispatch_rs1_addr = '0;
    dispatch_rs2_addr = '0;
    dispatch_rs1      = '0;
    dispatch_rs2      = '0;
    cyc               = 0;
    sent              = 0;
    prev_mul_v        = 1'b0;
    prev_mul_rd       = '0;
    div_pend          = 1'b0;
    div_rd            = '0;
    div_data          = '0;
    div_cyc           = 0;
    for (int i = 0; i < 4; i++)
      exp_v[i] = 1'b0;
    for (int r = 0; r < 32; r++)
    begin
      rf[r]      = (r == 0) ? '0 : $random(seed);
      gold_rf[r] = rf[r];
    end
    repeat (reset_cycles_lp)
    begin
      @(negedge clk);
      check_value("writeback valid in reset", 0, wb_v);
      check_value("divider busy in reset", 0, div_busy);
    end
    rst_n = 1'b1;
    while (sent < num_instr_lp)
    begin
      check_cycle();
      send_random();
    end
    do
    begin
      check_cycle();
      dispatch_v = 1'b0;
    end
    while (div_pend || fixed_pending());
    $display("Done: no errors");
    $finish;
  end

  initial
  begin
    #(num_instr_lp * (width_lp + 8) * clk_period_lp);
    $display("Watchdog expired before all results were written back");
    stop_with_failure();
  end

endmodule

// ==== project.f ====
+incdir+test
hw/calc_pkg.sv
hw/calc_issue.sv
hw/calc_pipe_int.sv
hw/calc_pipe_mul.sv
hw/calc_pipe_div.sv
hw/calc_completion.sv
hw/calc_top.sv
test/calc_tb.sv

// ==== Makefile ====
# Verilator simulation of the calculator testbench

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module calc_tb -f project.f
	./obj_dir/Vcalc_tb

clean:
	rm -rf obj_dir

.PHONY: sim clean
